/* include/rv32_defines.svh */
//############################
// core-wide width, register count and reset vector
//############################

`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

`define XLEN      32    // one word, also the address width
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC  32'h0000_0000

`endif

/* rtl/rv32Pkg.sv */
//############################
// opcode, mux-select, alu and state enums
// instruction word union with its six formats
//############################

package rv32Pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		RType      = 7'b0110011,
		ITypeLogic = 7'b0010011,
		ITypeLoad  = 7'b0000011,
		ITypeJalr  = 7'b1100111,
		SType      = 7'b0100011,
		BType      = 7'b1100011,
		JType      = 7'b1101111,
		UTypeLui   = 7'b0110111,
		UTypeAuipc = 7'b0010111
	} opcode_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_t    opcode;
	} instrR_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_t     opcode;
	} instrI_t;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcode_t    opcode;
	} instrS_t;

	// branch offset is scattered, bit 0 implied zero
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic       imm11;
		opcode_t    opcode;
	} instrB_t;

	typedef struct packed {
		logic [19:0] imm;    // upper 20 bits of the result
		logic [4:0]  rd;
		opcode_t     opcode;
	} instrU_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10to1;
		logic       imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		opcode_t    opcode;
	} instrJ_t;

	typedef union packed {
		instrR_t instrR;
		instrI_t instrI;
		instrS_t instrS;
		instrB_t instrB;
		instrU_t instrU;
		instrJ_t instrJ;
	} instrWord_u;

	typedef enum logic {AdrPc, AdrResult} adrSrc_t;
	typedef enum logic [1:0] {PcIncrement, PcJump, PcAluOut} pcSrc_t;
	typedef enum logic [1:0] {SrcARd1, SrcAOldPc, SrcAZero} aluSrcA_t;
	typedef enum logic [1:0] {SrcBRd2, SrcBImm, SrcBFour} aluSrcB_t;
	typedef enum logic {ResultAluOut, ResultData} resultSrc_t;
	typedef enum logic [1:0] {AluOpAdd, AluOpSub, AluOpRFunct, AluOpIFunct} aluOp_t;

	typedef enum logic [2:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSll, AluSrl
	} aluCtrl_t;

	typedef enum logic [3:0] {
		Fetch, Decode, ExecuteR, ExecuteI, UncondJump, JalrCalc, JalrStep2, Lui,
		Auipc, MemAdr, MemRead, MemWrite, MemWb, AluWb, BranchIfEq
	} fsmState_t;

endpackage

/* rtl/ControlFsm.sv */
//############################
// moore control fsm of the multicycle core
//############################

`timescale 1ns/1ps

module ControlFsm import rv32Pkg::*; (
	input logic clk,
	input logic reset,
	input instrWord_u instr,
	input logic zero,
	output adrSrc_t adrSrc,
	output logic irWrite,
	output logic regWrite,
	output logic pcWrite,
	output logic memWe,
	output pcSrc_t pcSrc,
	output aluSrcA_t aluSrcA,
	output aluSrcB_t aluSrcB,
	output aluOp_t aluOp,
	output resultSrc_t resultSrc
);

	fsmState_t state;
	fsmState_t nextState;
	opcode_t opcode;

	assign opcode = instr.instrR.opcode;    // same bits in every format

	always_ff @(posedge clk) begin
		if (reset)
			state <= Fetch;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = Fetch;
		case (state)
			Fetch: nextState = Decode;
			Decode: begin
				case (opcode)
					RType:            nextState = ExecuteR;
					ITypeLogic:       nextState = ExecuteI;
					ITypeLoad, SType: nextState = MemAdr;
					BType:            nextState = BranchIfEq;
					JType:            nextState = UncondJump;
					UTypeLui:         nextState = Lui;
					UTypeAuipc:       nextState = Auipc;
					ITypeJalr:        nextState = JalrCalc;
					default:          nextState = Decode;    // unknown opcode hangs here
				endcase
			end
			ExecuteR, ExecuteI, UncondJump, Lui, Auipc, JalrStep2: nextState = AluWb;
			JalrCalc: nextState = JalrStep2;
			MemAdr: nextState = (opcode == ITypeLoad) ? MemRead : MemWrite;
			MemRead: nextState = MemWb;
			MemWrite, MemWb, AluWb, BranchIfEq: nextState = Fetch;
			default: nextState = Fetch;
		endcase
	end

	// outputs depend on state only, apart from pcWrite in BranchIfEq
	always_comb begin
		adrSrc = AdrPc;
		irWrite = 1'b0;
		regWrite = 1'b0;
		pcWrite = 1'b0;
		memWe = 1'b0;
		pcSrc = PcIncrement;
		aluSrcA = SrcARd1;
		aluSrcB = SrcBRd2;
		aluOp = AluOpAdd;
		resultSrc = ResultAluOut;

		case (state)
			Fetch: begin
				irWrite = 1'b1;    // latch instr and old pc
				pcWrite = 1'b1;    // pc + 4
			end
			Decode: begin
				// old pc + imm lands in aluOut as branch/jal target
				aluSrcA = SrcAOldPc;
				aluSrcB = SrcBImm;
			end
			ExecuteR: begin
				aluOp = AluOpRFunct;
			end
			ExecuteI: begin
				aluSrcB = SrcBImm;
				aluOp = AluOpIFunct;
			end
			UncondJump: begin
				aluSrcA = SrcAOldPc;    // link value
				aluSrcB = SrcBFour;
				pcSrc = PcJump;
				pcWrite = 1'b1;
			end
			JalrCalc: begin
				aluSrcB = SrcBImm;    // rs1 + imm
			end
			JalrStep2: begin
				aluSrcA = SrcAOldPc;
				aluSrcB = SrcBFour;
				pcSrc = PcAluOut;    // target still in aluOut this cycle
				pcWrite = 1'b1;
			end
			Lui: begin
				aluSrcA = SrcAZero;
				aluSrcB = SrcBImm;
			end
			Auipc: begin
				aluSrcA = SrcAOldPc;
				aluSrcB = SrcBImm;
			end
			MemAdr: begin
				aluSrcB = SrcBImm;
			end
			MemRead: begin
				adrSrc = AdrResult;
			end
			MemWrite: begin
				adrSrc = AdrResult;
				memWe = 1'b1;
			end
			MemWb: begin
				resultSrc = ResultData;
				regWrite = 1'b1;
			end
			AluWb: begin
				regWrite = 1'b1;
			end
			BranchIfEq: begin
				aluOp = AluOpSub;
				pcSrc = PcJump;
				pcWrite = zero;    // taken only when rs1 == rs2
			end
		endcase
	end

endmodule

/* rtl/AluDecoder.sv */
//############################
// alu control from op class and funct fields
//############################

`timescale 1ns/1ps

module AluDecoder import rv32Pkg::*; (
	input aluOp_t aluOp,
	input instrWord_u instr,
	output aluCtrl_t aluCtrl
);

	logic [2:0] funct3;
	logic subBit;

	assign funct3 = instr.instrR.funct3;
	assign subBit = instr.instrR.funct7[5];

	always_comb begin
		case (aluOp)
			AluOpAdd: aluCtrl = AluAdd;
			AluOpSub: aluCtrl = AluSub;
			default: begin
				// register and immediate class share the funct3 map
				case (funct3)
					3'b000: begin
						// funct7 picks sub for r-type only, immediates always add
						if (aluOp == AluOpRFunct && subBit)
							aluCtrl = AluSub;
						else
							aluCtrl = AluAdd;
					end
					3'b001: aluCtrl = AluSll;
					3'b010: aluCtrl = AluSlt;
					3'b100: aluCtrl = AluXor;
					3'b101: aluCtrl = AluSrl;    // no sra/srai
					3'b110: aluCtrl = AluOr;
					3'b111: aluCtrl = AluAnd;
					default: aluCtrl = AluAdd;
				endcase
			end
		endcase
	end

endmodule

/* rtl/Alu.sv */
//############################
// 32-bit alu with zero flag
//############################

`timescale 1ns/1ps
`include "rv32_defines.svh"

module Alu import rv32Pkg::*; (
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input aluCtrl_t aluCtrl,
	output logic [`XLEN-1:0] result,
	output logic zero
);

	localparam int ShiftBits = $clog2(`XLEN);

	logic [ShiftBits-1:0] shamt;
	logic lessThan;

	assign shamt = b[ShiftBits-1:0];
	assign lessThan = $signed(a) < $signed(b);    // slt is signed

	always_comb begin
		case (aluCtrl)
			AluAdd: result = a + b;
			AluSub: result = a - b;
			AluAnd: result = a & b;
			AluOr:  result = a | b;
			AluXor: result = a ^ b;
			AluSlt: result = {{(`XLEN-1){1'b0}}, lessThan};
			AluSll: result = a << shamt;
			AluSrl: result = a >> shamt;
			default: result = a + b;
		endcase
	end

	// beq compares through sub
	assign zero = (result == '0);

endmodule

/* rtl/RegFile.sv */
//############################
// 32x32 register file, x0 reads zero
//############################

`timescale 1ns/1ps
`include "rv32_defines.svh"

module RegFile (
	input logic clk,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic [`XLEN-1:0] wd,
	input logic regWrite,
	output logic [`XLEN-1:0] rd1,
	output logic [`XLEN-1:0] rd2
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (regWrite && rd != 5'd0)    // writes to x0 dropped
			regs[rd] <= wd;
	end

	assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* rtl/ImmExtend.sv */
//############################
// immediate builder for i, s, b, u and j
//############################

`timescale 1ns/1ps
`include "rv32_defines.svh"

module ImmExtend import rv32Pkg::*; (
	input instrWord_u instr,
	output logic [`XLEN-1:0] immExt
);

	always_comb begin
		case (instr.instrI.opcode)
			ITypeLogic, ITypeLoad, ITypeJalr:
				immExt = {{(`XLEN-12){instr.instrI.imm[11]}}, instr.instrI.imm};
			SType:
				immExt = {{(`XLEN-12){instr.instrS.immHi[6]}}, instr.instrS.immHi,
					instr.instrS.immLo};
			BType:
				immExt = {{(`XLEN-12){instr.instrB.imm12}}, instr.instrB.imm11,
					instr.instrB.imm10to5, instr.instrB.imm4to1, 1'b0};
			JType:
				immExt = {{(`XLEN-20){instr.instrJ.imm20}}, instr.instrJ.imm19to12,
					instr.instrJ.imm11, instr.instrJ.imm10to1, 1'b0};
			// lui/auipc put the 20 bits on top
			UTypeLui, UTypeAuipc:
				immExt = {instr.instrU.imm, 12'b0};
			default:
				immExt = '0;    // r-type has no immediate
		endcase
	end

endmodule

/* rtl/MulticycleCore.sv */
//############################
// multicycle rv32i core, datapath registers and muxes
//############################

`timescale 1ns/1ps
`include "rv32_defines.svh"

module MulticycleCore import rv32Pkg::*; (
	input logic clk,
	input logic reset,
	output logic [`XLEN-1:0] memAddr,
	output logic [`XLEN-1:0] memWdata,
	output logic memWe,
	input logic [`XLEN-1:0] memRdata
);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] oldPc;
	logic [`XLEN-1:0] pcNext;
	instrWord_u instr;
	logic [`XLEN-1:0] aReg;
	logic [`XLEN-1:0] bReg;
	logic [`XLEN-1:0] aluOut;
	logic [`XLEN-1:0] dataReg;
	logic [`XLEN-1:0] rd1;
	logic [`XLEN-1:0] rd2;
	logic [`XLEN-1:0] immExt;
	logic [`XLEN-1:0] srcA;
	logic [`XLEN-1:0] srcB;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] result;
	logic zero;

	adrSrc_t adrSrc;
	logic irWrite;
	logic regWrite;
	logic pcWrite;
	pcSrc_t pcSrc;
	aluSrcA_t aluSrcA;
	aluSrcB_t aluSrcB;
	aluOp_t aluOp;
	resultSrc_t resultSrc;
	aluCtrl_t aluCtrl;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `RESET_PC;
		else if (pcWrite)
			pc <= pcNext;
	end

	// instr and the pc it came from move together
	always_ff @(posedge clk) begin
		if (irWrite) begin
			oldPc <= pc;
			instr <= memRdata;
		end
	end

	always_ff @(posedge clk) begin
		aReg <= rd1;
		bReg <= rd2;
		aluOut <= aluResult;
		dataReg <= memRdata;    // load data, used in MemWb
	end

	always_comb begin
		case (pcSrc)
			PcJump:   pcNext = aluOut;
			PcAluOut: pcNext = {aluOut[`XLEN-1:1], 1'b0};    // jalr clears bit 0
			default:  pcNext = pc + `XLEN'd4;
		endcase
	end

	always_comb begin
		case (aluSrcA)
			SrcAOldPc: srcA = oldPc;
			SrcAZero:  srcA = '0;
			default:   srcA = aReg;
		endcase
	end

	always_comb begin
		case (aluSrcB)
			SrcBImm:  srcB = immExt;
			SrcBFour: srcB = `XLEN'd4;
			default:  srcB = bReg;
		endcase
	end

	assign result = (resultSrc == ResultData) ? dataReg : aluOut;
	assign memAddr = (adrSrc == AdrResult) ? result : pc;
	assign memWdata = bReg;

	ControlFsm fsm (
		.clk(clk), .reset(reset), .instr(instr), .zero(zero),
		.adrSrc(adrSrc), .irWrite(irWrite), .regWrite(regWrite),
		.pcWrite(pcWrite), .memWe(memWe), .pcSrc(pcSrc),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
		.resultSrc(resultSrc)
	);

	AluDecoder aluDec (.aluOp(aluOp), .instr(instr), .aluCtrl(aluCtrl));

	Alu alu (.a(srcA), .b(srcB), .aluCtrl(aluCtrl), .result(aluResult), .zero(zero));

	RegFile regFile (
		.clk(clk), .rs1(instr.instrR.rs1), .rs2(instr.instrR.rs2),
		.rd(instr.instrR.rd), .wd(result), .regWrite(regWrite),
		.rd1(rd1), .rd2(rd2)
	);

	ImmExtend immGen (.instr(instr), .immExt(immExt));

endmodule

/* bench/Core_props.sv */
//############################
// memory port assertions
//############################

`timescale 1ns/1ps
`include "rv32_defines.svh"

module CoreProps (
	input logic clk,
	input logic reset,
	input logic memWe,
	input logic [`XLEN-1:0] memAddr
);

	int failCount = 0;

	// a store lasts exactly one MemWrite cycle
	singleStoreCycle: assert property (@(posedge clk) memWe |=> !memWe)
		else begin
			failCount++;
			$error("memWe high in two consecutive cycles");
		end

	noStoreInReset: assert property (@(posedge clk) reset |-> !memWe)
		else begin
			failCount++;
			$error("memWe high during reset");
		end

	alignedStore: assert property (@(posedge clk) memWe |-> memAddr[1:0] == 2'b00)
		else begin
			failCount++;
			$error("store address not word aligned");
		end

endmodule

/* bench/CoreTb.sv */
//##############################
// clock, reset, lfsr program generator, isa model,
// memory model, store checker and watchdog
//##############################

`timescale 1ns/1ps
`include "rv32_defines.svh"

module CoreTb import rv32Pkg::*; ();

	localparam int MemWords = 1024;
	localparam int DataBase = 'h600;    // sw/lw scratch words
	localparam int DumpBase = 'h700;    // final register dump
	localparam int Groups = 48;
	localparam int MaxSteps = 4096;

	logic clk;
	logic reset;
	logic [`XLEN-1:0] memAddr;
	logic [`XLEN-1:0] memWdata;
	logic [`XLEN-1:0] memRdata;
	logic memWe;

	logic [`XLEN-1:0] mem [MemWords];
	logic [`XLEN-1:0] refMem [MemWords];
	logic [`XLEN-1:0] refRegs [`REG_COUNT];
	logic [`XLEN-1:0] expAddr [$];
	logic [`XLEN-1:0] expData [$];
	logic [31:0] lfsr;
	logic [`XLEN-1:0] endPc;    // address of the final self-jump
	int codeLen;
	int modelSteps;
	int watchCycles;
	int errorCount;
	int checkCount;

	MulticycleCore DUT (
		.clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
		.memWe(memWe), .memRdata(memRdata)
	);

	bind MulticycleCore CoreProps props (
		.clk(clk), .reset(reset), .memWe(memWe), .memAddr(memAddr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, RType};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input opcode_t op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], SType};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], BType};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
		input opcode_t op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JType};
	endfunction

	task automatic emit(input logic [31:0] word);
		mem[codeLen] = word;
		codeLen++;
	endtask

	task automatic emitAluOp();
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic isReg;
		logic alt;
		f3 = randBits(3);
		rd = randBits(5);
		rs1 = randBits(5);
		rs2 = randBits(5);
		isReg = randBits(1);
		alt = randBits(1);
		if (f3 == 3'b011)
			f3 = 3'b000;    // no sltu in the subset
		if (isReg)
			emit(encR((f3 == 3'b000 && alt) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
		else if (f3 == 3'b001 || f3 == 3'b101)
			emit(encI({7'h00, rs2}, rs1, f3, rd, ITypeLogic));    // shamt sits in the rs2 slot
		else
			emit(encI(randBits(12), rs1, f3, rd, ITypeLogic));
	endtask

	task automatic buildProgram();
		logic [4:0] r1;
		logic [4:0] r2;
		logic [2:0] kind;
		logic [11:0] off;
		codeLen = 0;
		for (int r = 1; r < 32; r++) begin
			emit(encU(randBits(20), r, UTypeLui));
			emit(encI(randBits(12), r, 3'b000, r, ITypeLogic));
		end
		for (int g = 0; g < Groups; g++) begin
			kind = randBits(3);
			r1 = randBits(5);
			r2 = randBits(5);
			off = DataBase + 4 * randBits(6);
			case (kind)
				3'd4: begin
					emit(encS(off, r1, 5'd0));
					emit(encI(off, 5'd0, 3'b010, r2, ITypeLoad));    // read the word back
				end
				3'd5: begin
					// equal operands about half the time
					emit(encB(13'd8, randBits(1) ? r1 : r2, r1));
					emitAluOp();
				end
				3'd6: begin
					emit(encJ(21'd8, r1));
					emitAluOp();
				end
				3'd7: begin
					if (r1 == 5'd0)
						r1 = 5'd1;    // x0 base would jump back to address 12
					// auipc + 13 with bit 0 dropped lands past one op
					emit(encU(20'd0, r1, UTypeAuipc));
					emit(encI(12'd13, r1, 3'b000, r2, ITypeJalr));
					emitAluOp();
				end
				default: emitAluOp();
			endcase
		end
		for (int r = 0; r < 32; r++)
			emit(encS(DumpBase + 4 * r, r, 5'd0));
		endPc = codeLen * 4;
		emit(encJ(21'd0, 5'd0));
	endtask

	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic setReg(input logic [4:0] r, input logic [31:0] v);
		if (r != 5'd0)
			refRegs[r] = v;
	endtask

	// isa model that collects the expected stores in order
	task automatic runModel();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ea;
		logic [31:0] immI;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] immU;
		logic [4:0] rd;
		pc = `RESET_PC;
		modelSteps = 0;
		refRegs[0] = '0;
		while (pc != endPc && modelSteps < MaxSteps) begin
			ins = refMem[pc[11:2]];
			rd = ins[11:7];
			a = refRegs[ins[19:15]];
			b = refRegs[ins[24:20]];
			immI = {{20{ins[31]}}, ins[31:20]};
			immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			immU = {ins[31:12], 12'b0};
			npc = pc + 4;
			modelSteps++;
			case (ins[6:0])
				RType: setReg(rd, aluModel(ins[14:12], ins[30], a, b));
				ITypeLogic: setReg(rd, aluModel(ins[14:12], 1'b0, a, immI));
				ITypeLoad: begin
					ea = a + immI;
					setReg(rd, refMem[ea[11:2]]);
				end
				SType: begin
					ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					refMem[ea[11:2]] = b;
					expAddr.push_back(ea);
					expData.push_back(b);
				end
				BType: if (a == b) npc = pc + immB;
				JType: begin
					setReg(rd, pc + 4);
					npc = pc + immJ;
				end
				ITypeJalr: begin
					npc = (a + immI) & ~32'd1;
					setReg(rd, pc + 4);
				end
				UTypeLui: setReg(rd, immU);
				UTypeAuipc: setReg(rd, pc + immU);
				default: begin
					$display("model met an unknown opcode at %h", pc);
					errorCount++;
				end
			endcase
			pc = npc;
		end
		if (pc != endPc) begin
			$display("model never reached the final jump");
			errorCount++;
		end
	endtask

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		if (got !== expected) begin
			$display("error %s: got %h, expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	// called at the falling edge so read data settles before the next rising edge
	task automatic serviceMemory();
		if (memWe) begin
			if (expAddr.size() == 0) begin
				$display("store to %h came after the last expected store", memAddr);
				errorCount++;
			end else begin
				compareValue("memAddr", memAddr, expAddr.pop_front());
				compareValue("memWdata", memWdata, expData.pop_front());
			end
			mem[memAddr[11:2]] = memWdata;
		end
		memRdata = mem[memAddr[11:2]];
	endtask

	initial begin
		int jumpsBack;
		logic [31:0] lastAddr;
		reset = 1'b1;
		memRdata = '0;
		errorCount = 0;
		checkCount = 0;
		watchCycles = 0;
		lfsr = 32'd20;
		for (int i = 0; i < MemWords; i++)
			mem[i] = 32'hA5A5_0000 ^ (i * 4);    // unused words carry their address
		buildProgram();
		refMem = mem;
		runModel();
		watchCycles = modelSteps * 5 + 40;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		compareValue("memAddr", memAddr, `RESET_PC);
		jumpsBack = 0;
		lastAddr = memAddr;
		// self-jump seen returning twice
		while (jumpsBack < 2) begin
			serviceMemory();
			@(negedge clk);
			if (lastAddr == endPc + 4 && memAddr == endPc)
				jumpsBack++;
			lastAddr = memAddr;
		end
		if (expAddr.size() != 0) begin
			$display("%0d expected stores never happened", expAddr.size());
			errorCount++;
		end
		errorCount += DUT.props.failCount;
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		wait (watchCycles > 0);
		repeat (watchCycles) @(posedge clk);
		$display("the core hung, final jump not reached within %0d cycles", watchCycles);
		errorCount++;
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		$display("tests failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+include
rtl/rv32Pkg.sv
rtl/ControlFsm.sv
rtl/AluDecoder.sv
rtl/Alu.sv
rtl/RegFile.sv
rtl/ImmExtend.sv
rtl/MulticycleCore.sv
bench/Core_props.sv
bench/CoreTb.sv
